/* Bender.yml */
package:
  name: mci_lite

sources:
  - src/mci_lite_pkg.sv
  - src/mci_host_port.sv
  - src/mci_csr.sv
  - src/mci_wdt.sv
  - src/mci_err_agg.sv
  - src/mci_lite_top.sv
  - target: test
    files:
      - dv/mci_lite_tb.sv

/* dv/mci_lite_tb.sv */
`timescale 1ns/10ps

module mci_lite_tb;

    localparam int          ERR_W        = 8;
    localparam int          GEN_W        = 16;
    localparam int          HALF_PERIOD  = 50;
    localparam int          RESET_CYCLES = 10;
    localparam int          ACK_LIMIT    = 8;
    localparam int          HOLD_CYCLES  = 4;
    localparam int          OP_SLACK     = 20;
    localparam int          MAX_OPS      = 256;
    localparam logic [31:0] RAND_SEED    = 32'h81d0_f241;

    logic             clk;
    logic             rst_n;
    logic             host_req;
    logic             host_we;
    logic [3:0]       host_addr;
    logic [31:0]      host_wdata;
    logic             host_ack;
    logic [31:0]      host_rdata;
    logic [ERR_W-1:0] err_fatal;
    logic [ERR_W-1:0] err_non_fatal;
    logic [GEN_W-1:0] gen_in;
    logic [GEN_W-1:0] gen_out;
    logic             all_fatal;
    logic             all_non_fatal;
    logic             mci_intr;
    logic             nmi_intr;

    // Operations parsed from the test file
    logic [7:0]  op_mem  [0:MAX_OPS-1];
    logic [31:0] arg_mem [0:MAX_OPS-1][0:4];
    int          n_ops;
    int          budget_cycles;
    logic        tests_loaded;
    int          mismatch_cnt;
    int          other_cnt;

    initial clk = 1'b0;
    always #HALF_PERIOD clk = ~clk;

    mci_lite_top #(
        .ERR_W (ERR_W),
        .GEN_W (GEN_W)
    ) dut (
        .clk                        (clk),
        .rst_n_i                    (rst_n),
        .host_req_i                 (host_req),
        .host_we_i                  (host_we),
        .host_addr_i                (host_addr),
        .host_wdata_i               (host_wdata),
        .host_ack_o                 (host_ack),
        .host_rdata_o               (host_rdata),
        .agg_error_fatal_i          (err_fatal),
        .agg_error_non_fatal_i      (err_non_fatal),
        .mci_generic_input_wires_i  (gen_in),
        .mci_generic_output_wires_o (gen_out),
        .all_error_fatal_o          (all_fatal),
        .all_error_non_fatal_o      (all_non_fatal),
        .mci_intr_o                 (mci_intr),
        .nmi_intr_o                 (nmi_intr)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, got);
            mismatch_cnt++;
        end
    endtask

    ////////////////////
    // Test file loading
    ////////////////////

    task automatic load_tests();
        int               fd;
        int               nread;
        int               want;
        int               wait_sum;
        logic [7:0]       op;
        logic [31:0]      f0;
        logic [31:0]      f1;
        logic [31:0]      f2;
        logic [31:0]      f3;
        logic [31:0]      f4;
        logic [8*128-1:0] rest;
        n_ops    = 0;
        wait_sum = 0;
        fd       = $fopen("dv/mci_lite_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test file dv/mci_lite_tests.txt");
            other_cnt++;
        end else begin
            while (!$feof(fd) && n_ops < MAX_OPS) begin
                nread = $fscanf(fd, " %c", op);
                if (nread == 1) begin
                    f0 = '0;
                    f1 = '0;
                    f2 = '0;
                    f3 = '0;
                    f4 = '0;
                    want = 0;
                    case (op)
                        "#": nread = $fgets(rest, fd);
                        "W", "R", "H": begin
                            nread = $fscanf(fd, "%h %h", f0, f1);
                            want  = 2;
                        end
                        "I": begin
                            nread = $fscanf(fd, "%h %h %h", f0, f1, f2);
                            want  = 3;
                        end
                        "D": begin
                            nread = $fscanf(fd, "%d", f0);
                            want  = 1;
                        end
                        "C": begin
                            nread = $fscanf(fd, "%h %h %h %h %h", f0, f1, f2, f3, f4);
                            want  = 5;
                        end
                        default: begin
                            $display("Unknown operation '%c' in the test file", op);
                            other_cnt++;
                            nread = $fgets(rest, fd);
                        end
                    endcase
                    if (want > 0 && nread != want) begin
                        $display("Malformed '%c' line in the test file", op);
                        other_cnt++;
                    end else if (want > 0) begin
                        op_mem[n_ops]     = op;
                        arg_mem[n_ops][0] = f0;
                        arg_mem[n_ops][1] = f1;
                        arg_mem[n_ops][2] = f2;
                        arg_mem[n_ops][3] = f3;
                        arg_mem[n_ops][4] = f4;
                        if (op == "D") begin
                            wait_sum += f0;
                        end
                        n_ops++;
                    end
                end
            end
            $fclose(fd);
        end
        // One extra slot of slack covers the reset phase
        budget_cycles = wait_sum + OP_SLACK * (n_ops + 1);
        tests_loaded  = 1'b1;
    endtask

    ////////////////////
    // Host handshake
    ////////////////////

    // Called on a falling edge, returns on a falling edge with ack low
    task automatic host_access(input logic we, input logic [3:0] addr,
                               input logic [31:0] wdata, input int hold,
                               output logic [31:0] rdata);
        int waited;
        int gap;
        gap = $urandom % 4;
        repeat (gap) @(negedge clk);
        host_req   = 1'b1;
        host_we    = we;
        host_addr  = addr;
        host_wdata = wdata;
        rdata      = '0;
        waited     = 0;
        while (!host_ack && waited < ACK_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!host_ack) begin
            $display("Handshake failed at %0t ns: no ack for address %h", $time, addr);
            other_cnt++;
            host_req = 1'b0;
            host_we  = 1'b0;
        end else begin
            rdata = host_rdata;
            // Held request must keep ack up
            repeat (hold) begin
                @(negedge clk);
                check_value("host_ack_o", {31'b0, host_ack}, 32'd1);
            end
            host_req = 1'b0;
            host_we  = 1'b0;
            waited   = 0;
            while (host_ack && waited < ACK_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (host_ack) begin
                $display("Handshake failed at %0t ns: ack stayed high after req fell", $time);
                other_cnt++;
            end
        end
    endtask

    task automatic run_op(input int idx);
        logic [7:0]  op;
        logic [31:0] a0;
        logic [31:0] a1;
        logic [31:0] a2;
        logic [31:0] a3;
        logic [31:0] a4;
        logic [31:0] rd;
        op = op_mem[idx];
        a0 = arg_mem[idx][0];
        a1 = arg_mem[idx][1];
        a2 = arg_mem[idx][2];
        a3 = arg_mem[idx][3];
        a4 = arg_mem[idx][4];
        case (op)
            "W": host_access(1'b1, a0[3:0], a1, 0, rd);
            "H": host_access(1'b1, a0[3:0], a1, HOLD_CYCLES, rd);
            "R": begin
                host_access(1'b0, a0[3:0], 32'h0, 0, rd);
                check_value("host_rdata_o", rd, a1);
            end
            "I": begin
                err_fatal     = a0[ERR_W-1:0];
                err_non_fatal = a1[ERR_W-1:0];
                gen_in        = a2[GEN_W-1:0];
            end
            "D": repeat (a0) @(negedge clk);
            "C": begin
                check_value("all_error_fatal_o", {31'b0, all_fatal}, a0);
                check_value("all_error_non_fatal_o", {31'b0, all_non_fatal}, a1);
                check_value("mci_intr_o", {31'b0, mci_intr}, a2);
                check_value("nmi_intr_o", {31'b0, nmi_intr}, a3);
                check_value("mci_generic_output_wires_o", {16'b0, gen_out}, a4);
            end
            default: begin
                $display("Operation %0d has no handler", idx);
                other_cnt++;
            end
        endcase
    endtask

    initial begin : main
        int idx;
        rst_n         = 1'b0;
        host_req      = 1'b0;
        host_we       = 1'b0;
        host_addr     = '0;
        host_wdata    = '0;
        err_fatal     = '0;
        err_non_fatal = '0;
        gen_in        = '0;
        tests_loaded  = 1'b0;
        mismatch_cnt  = 0;
        other_cnt     = 0;
        void'($urandom(RAND_SEED));
        load_tests();
        if (n_ops == 0) begin
            $display("No operations found in the test file");
            other_cnt++;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        for (idx = 0; idx < n_ops; idx++) begin
            run_op(idx);
        end
        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Ends a hung run
    initial begin : watchdog
        wait (tests_loaded === 1'b1);
        repeat (budget_cycles) @(posedge clk);
        $display("Timeout: tests did not finish within %0d cycles", budget_cycles);
        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        $display("Done: errors found");
        $finish;
    end

endmodule

/* dv/mci_lite_tests.txt */
# W addr data | R addr expected | H addr data (held req) | D cycles (decimal)
# I fatal nonfatal generic_in | C fatal nonfatal mci_intr nmi generic_out (all else hex)
C 0 0 0 0 0000
I 00 00 a5c3
W 1 0000abcd
R 1 0000abcd
W 2 12345678
R 2 12345678
W 6 000000f0
R 6 000000f0
W 7 0000000f
R 7 0000000f
W 8 0000beef
R 8 0000beef
C 0 0 0 0 beef
R 9 0000a5c3
I 00 00 3c5a
R 9 00003c5a
W c ffffffff
R c 00000000
# Held request
H 6 00000055
R 6 00000055
# Timer 1
W 1 00000014
W 2 0000ffff
W 0 00000001
R 3 00000000
R 0 00000001
D 60
R 3 00000001
C 0 0 1 0 beef
# Cascade into timer 2
W 2 00000014
W 0 00000005
D 60
R 3 00000003
C 0 0 1 1 beef
W 3 00000003
D 2
C 0 0 0 0 beef
W 0 00000000
R 3 00000000
# Fatal errors
W 6 00000000
W 7 00000000
I 09 00 3c5a
D 1
I 00 00 3c5a
D 2
R 4 00000009
C 1 0 0 0 beef
W 6 00000009
D 2
C 0 0 0 0 beef
R 4 00000009
W 4 00000009
R 4 00000000
W 6 00000000
D 2
C 0 0 0 0 beef
# Non-fatal errors
I 00 06 3c5a
D 1
I 00 00 3c5a
D 2
R 5 00000006
C 0 1 1 0 beef
W 7 00000006
D 2
C 0 0 0 0 beef
W 5 00000006
R 5 00000000
W 7 00000000
D 2
C 0 0 0 0 beef

/* list.f */
src/mci_lite_pkg.sv
src/mci_host_port.sv
src/mci_csr.sv
src/mci_wdt.sv
src/mci_err_agg.sv
src/mci_lite_top.sv
dv/mci_lite_tb.sv

/* src/mci_csr.sv */
`timescale 1ns/10ps

module mci_csr #(
    parameter int ERR_W = 8,
    parameter int GEN_W = 16
) (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            acc_valid_i,
    input  logic                            acc_we_i,
    input  mci_lite_pkg::csr_addr_e         acc_addr_i,
    input  logic [mci_lite_pkg::DATA_W-1:0] acc_wdata_i,
    output logic [mci_lite_pkg::DATA_W-1:0] acc_rdata_o,
    output logic                            t1_en_o,
    output logic                            t1_restart_o,
    output logic                            t2_restart_o,
    output logic [mci_lite_pkg::DATA_W-1:0] t1_period_o,
    output logic [mci_lite_pkg::DATA_W-1:0] t2_period_o,
    output logic                            t1_serviced_o,
    output logic                            t2_serviced_o,
    input  logic                            t1_timeout_i,
    input  logic                            t2_timeout_i,
    output logic                            fatal_clr_o,
    output logic                            nonfatal_clr_o,
    output logic                            fatal_mask_we_o,
    output logic                            nonfatal_mask_we_o,
    output logic [ERR_W-1:0]                err_wdata_o,
    input  logic [ERR_W-1:0]                fatal_sts_i,
    input  logic [ERR_W-1:0]                nonfatal_sts_i,
    input  logic [ERR_W-1:0]                fatal_mask_i,
    input  logic [ERR_W-1:0]                nonfatal_mask_i,
    input  logic [GEN_W-1:0]                generic_in_i,
    output logic [GEN_W-1:0]                generic_out_o
);
    import mci_lite_pkg::*;

    wdt_ctrl_u         wdata_u;
    wdt_ctrl_u         ctrl_rd_u;
    logic              wr_en;
    logic              t1_en_q;
    logic [DATA_W-1:0] t1_period_q;
    logic [DATA_W-1:0] t2_period_q;
    logic [GEN_W-1:0]  gen_out_q;

    assign wdata_u = wdt_ctrl_u'(acc_wdata_i);
    assign wr_en   = acc_valid_i & acc_we_i;

    ////////////////////
    // Write strobes
    ////////////////////

    assign t1_restart_o  = wr_en && (acc_addr_i == WDT_CTRL) && wdata_u.ctrl.t1_restart;
    assign t2_restart_o  = wr_en && (acc_addr_i == WDT_CTRL) && wdata_u.ctrl.t2_restart;
    // W1C of the timeout flags
    assign t1_serviced_o = wr_en && (acc_addr_i == WDT_STATUS) && wdata_u.raw[0];
    assign t2_serviced_o = wr_en && (acc_addr_i == WDT_STATUS) && wdata_u.raw[1];

    assign fatal_clr_o        = wr_en && (acc_addr_i == ERR_FATAL_STS);
    assign nonfatal_clr_o     = wr_en && (acc_addr_i == ERR_NONFATAL_STS);
    assign fatal_mask_we_o    = wr_en && (acc_addr_i == ERR_FATAL_MASK);
    assign nonfatal_mask_we_o = wr_en && (acc_addr_i == ERR_NONFATAL_MASK);
    assign err_wdata_o        = wdata_u.raw[ERR_W-1:0];

    // Local registers
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            t1_en_q     <= 1'b0;
            t1_period_q <= '0;
            t2_period_q <= '0;
            gen_out_q   <= '0;
        end else if (wr_en) begin
            case (acc_addr_i)
                WDT_CTRL:      t1_en_q     <= wdata_u.ctrl.t1_en;
                WDT_T1_PERIOD: t1_period_q <= wdata_u.raw;
                WDT_T2_PERIOD: t2_period_q <= wdata_u.raw;
                GENERIC_OUT:   gen_out_q   <= wdata_u.raw[GEN_W-1:0];
                default:       ;
            endcase
        end
    end

    ////////////////////
    // Read mux
    ////////////////////

    always_comb begin
        ctrl_rd_u            = '0;
        ctrl_rd_u.ctrl.t1_en = t1_en_q;
        case (acc_addr_i)
            WDT_CTRL:          acc_rdata_o = ctrl_rd_u.raw;
            WDT_T1_PERIOD:     acc_rdata_o = t1_period_q;
            WDT_T2_PERIOD:     acc_rdata_o = t2_period_q;
            WDT_STATUS:        acc_rdata_o = {{(DATA_W-2){1'b0}}, t2_timeout_i, t1_timeout_i};
            ERR_FATAL_STS:     acc_rdata_o = DATA_W'(fatal_sts_i);
            ERR_NONFATAL_STS:  acc_rdata_o = DATA_W'(nonfatal_sts_i);
            ERR_FATAL_MASK:    acc_rdata_o = DATA_W'(fatal_mask_i);
            ERR_NONFATAL_MASK: acc_rdata_o = DATA_W'(nonfatal_mask_i);
            GENERIC_OUT:       acc_rdata_o = DATA_W'(gen_out_q);
            GENERIC_IN:        acc_rdata_o = DATA_W'(generic_in_i);
            default:           acc_rdata_o = '0;
        endcase
    end

    assign t1_en_o       = t1_en_q;
    assign t1_period_o   = t1_period_q;
    assign t2_period_o   = t2_period_q;
    assign generic_out_o = gen_out_q;

endmodule

/* src/mci_err_agg.sv */
`timescale 1ns/10ps

module mci_err_agg #(
    parameter int ERR_W = 8
) (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic [ERR_W-1:0] agg_error_fatal_i,
    input  logic [ERR_W-1:0] agg_error_non_fatal_i,
    input  logic             fatal_clr_i,
    input  logic             nonfatal_clr_i,
    input  logic             fatal_mask_we_i,
    input  logic             nonfatal_mask_we_i,
    input  logic [ERR_W-1:0] err_wdata_i,
    input  logic             t1_timeout_i,
    input  logic             t2_timeout_i,
    output logic [ERR_W-1:0] fatal_sts_o,
    output logic [ERR_W-1:0] nonfatal_sts_o,
    output logic [ERR_W-1:0] fatal_mask_o,
    output logic [ERR_W-1:0] nonfatal_mask_o,
    output logic             all_error_fatal_o,
    output logic             all_error_non_fatal_o,
    output logic             mci_intr_o,
    output logic             nmi_intr_o
);

    logic [ERR_W-1:0] fatal_clr_bits;
    logic [ERR_W-1:0] nonfatal_clr_bits;
    logic             fatal_any;
    logic             nonfatal_any;

    assign fatal_clr_bits    = fatal_clr_i ? err_wdata_i : '0;
    assign nonfatal_clr_bits = nonfatal_clr_i ? err_wdata_i : '0;

    // Sticky status where a new error beats a W1C in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            fatal_sts_o     <= '0;
            nonfatal_sts_o  <= '0;
            fatal_mask_o    <= '0;
            nonfatal_mask_o <= '0;
        end else begin
            fatal_sts_o    <= (fatal_sts_o & ~fatal_clr_bits) | agg_error_fatal_i;
            nonfatal_sts_o <= (nonfatal_sts_o & ~nonfatal_clr_bits) | agg_error_non_fatal_i;
            if (fatal_mask_we_i) begin
                fatal_mask_o <= err_wdata_i;
            end
            if (nonfatal_mask_we_i) begin
                nonfatal_mask_o <= err_wdata_i;
            end
        end
    end

    assign fatal_any    = |(fatal_sts_o & ~fatal_mask_o);
    assign nonfatal_any = |(nonfatal_sts_o & ~nonfatal_mask_o);

    ////////////////////
    // Interrupt outputs
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            all_error_fatal_o     <= 1'b0;
            all_error_non_fatal_o <= 1'b0;
            mci_intr_o            <= 1'b0;
            nmi_intr_o            <= 1'b0;
        end else begin
            all_error_fatal_o     <= fatal_any;
            all_error_non_fatal_o <= nonfatal_any;
            mci_intr_o            <= t1_timeout_i | nonfatal_any;
            nmi_intr_o            <= t2_timeout_i;
        end
    end

endmodule

/* src/mci_host_port.sv */
`timescale 1ns/10ps

module mci_host_port (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            host_req_i,
    input  logic                            host_we_i,
    input  logic [mci_lite_pkg::ADDR_W-1:0] host_addr_i,
    input  logic [mci_lite_pkg::DATA_W-1:0] host_wdata_i,
    output logic                            host_ack_o,
    output logic [mci_lite_pkg::DATA_W-1:0] host_rdata_o,
    output logic                            acc_valid_o,
    output logic                            acc_we_o,
    output mci_lite_pkg::csr_addr_e         acc_addr_o,
    output logic [mci_lite_pkg::DATA_W-1:0] acc_wdata_o,
    input  logic [mci_lite_pkg::DATA_W-1:0] acc_rdata_i
);
    import mci_lite_pkg::*;

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_ACCESS = 2'd1;
    localparam logic [1:0] ST_ACK    = 2'd2;

    logic [1:0] state_q;
    logic [1:0] state_d;

    // Handshake FSM that makes one access per request
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (host_req_i) begin
                    state_d = ST_ACCESS;
                end
            end
            ST_ACCESS: begin
                state_d = ST_ACK;
            end
            ST_ACK: begin
                // Held request just keeps ack up
                if (!host_req_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Read data sampled at the end of the access cycle
    always_ff @(posedge clk) begin
        if (state_q == ST_ACCESS) begin
            host_rdata_o <= acc_rdata_i;
        end
    end

    assign host_ack_o  = (state_q == ST_ACK);
    assign acc_valid_o = (state_q == ST_ACCESS);
    assign acc_we_o    = host_we_i;
    assign acc_addr_o  = csr_addr_e'(host_addr_i);
    assign acc_wdata_o = host_wdata_i;

endmodule

/* src/mci_lite_pkg.sv */
package mci_lite_pkg;

    ////////////////////
    // Bus widths
    ////////////////////

    localparam int DATA_W = 32;
    localparam int ADDR_W = 4;

    ////////////////////
    // Register map
    ////////////////////

    // Word addresses seen by the host port
    typedef enum logic [ADDR_W-1:0] {
        WDT_CTRL          = 4'd0,
        WDT_T1_PERIOD     = 4'd1,
        WDT_T2_PERIOD     = 4'd2,
        WDT_STATUS        = 4'd3,
        ERR_FATAL_STS     = 4'd4,
        ERR_NONFATAL_STS  = 4'd5,
        ERR_FATAL_MASK    = 4'd6,
        ERR_NONFATAL_MASK = 4'd7,
        GENERIC_OUT       = 4'd8,
        GENERIC_IN        = 4'd9
    } csr_addr_e;

    // Watchdog control word fields
    typedef struct packed {
        logic [DATA_W-4:0] pad;
        logic              t2_restart;
        logic              t1_restart;
        logic              t1_en;
    } wdt_ctrl_t;

    // Same word seen as fields or as a plain value
    typedef union packed {
        wdt_ctrl_t         ctrl;
        logic [DATA_W-1:0] raw;
    } wdt_ctrl_u;

endpackage

/* src/mci_lite_top.sv */
`timescale 1ns/10ps

module mci_lite_top #(
    parameter int ERR_W = 8,
    parameter int GEN_W = 16
) (
    input  logic                            clk,
    input  logic                            rst_n_i,
    // Host register port
    input  logic                            host_req_i,
    input  logic                            host_we_i,
    input  logic [mci_lite_pkg::ADDR_W-1:0] host_addr_i,
    input  logic [mci_lite_pkg::DATA_W-1:0] host_wdata_i,
    output logic                            host_ack_o,
    output logic [mci_lite_pkg::DATA_W-1:0] host_rdata_o,
    // SoC error sources
    input  logic [ERR_W-1:0]                agg_error_fatal_i,
    input  logic [ERR_W-1:0]                agg_error_non_fatal_i,
    input  logic [GEN_W-1:0]                mci_generic_input_wires_i,
    output logic [GEN_W-1:0]                mci_generic_output_wires_o,
    output logic                            all_error_fatal_o,
    output logic                            all_error_non_fatal_o,
    output logic                            mci_intr_o,
    output logic                            nmi_intr_o
);
    import mci_lite_pkg::*;

    // Register access
    logic              acc_valid;
    logic              acc_we;
    csr_addr_e         acc_addr;
    logic [DATA_W-1:0] acc_wdata;
    logic [DATA_W-1:0] acc_rdata;

    // Watchdog
    logic              t1_en;
    logic              t1_restart;
    logic              t2_restart;
    logic [DATA_W-1:0] t1_period;
    logic [DATA_W-1:0] t2_period;
    logic              t1_serviced;
    logic              t2_serviced;
    logic              t1_timeout;
    logic              t2_timeout;

    // Error aggregation
    logic              fatal_clr;
    logic              nonfatal_clr;
    logic              fatal_mask_we;
    logic              nonfatal_mask_we;
    logic [ERR_W-1:0]  err_wdata;
    logic [ERR_W-1:0]  fatal_sts;
    logic [ERR_W-1:0]  nonfatal_sts;
    logic [ERR_W-1:0]  fatal_mask;
    logic [ERR_W-1:0]  nonfatal_mask;

    mci_host_port i_host_port (
        .clk,
        .rst_n_i,
        .host_req_i,
        .host_we_i,
        .host_addr_i,
        .host_wdata_i,
        .host_ack_o,
        .host_rdata_o,
        .acc_valid_o (acc_valid),
        .acc_we_o    (acc_we),
        .acc_addr_o  (acc_addr),
        .acc_wdata_o (acc_wdata),
        .acc_rdata_i (acc_rdata)
    );

    mci_csr #(
        .ERR_W (ERR_W),
        .GEN_W (GEN_W)
    ) i_csr (
        .clk,
        .rst_n_i,
        .acc_valid_i        (acc_valid),
        .acc_we_i           (acc_we),
        .acc_addr_i         (acc_addr),
        .acc_wdata_i        (acc_wdata),
        .acc_rdata_o        (acc_rdata),
        .t1_en_o            (t1_en),
        .t1_restart_o       (t1_restart),
        .t2_restart_o       (t2_restart),
        .t1_period_o        (t1_period),
        .t2_period_o        (t2_period),
        .t1_serviced_o      (t1_serviced),
        .t2_serviced_o      (t2_serviced),
        .t1_timeout_i       (t1_timeout),
        .t2_timeout_i       (t2_timeout),
        .fatal_clr_o        (fatal_clr),
        .nonfatal_clr_o     (nonfatal_clr),
        .fatal_mask_we_o    (fatal_mask_we),
        .nonfatal_mask_we_o (nonfatal_mask_we),
        .err_wdata_o        (err_wdata),
        .fatal_sts_i        (fatal_sts),
        .nonfatal_sts_i     (nonfatal_sts),
        .fatal_mask_i       (fatal_mask),
        .nonfatal_mask_i    (nonfatal_mask),
        .generic_in_i       (mci_generic_input_wires_i),
        .generic_out_o      (mci_generic_output_wires_o)
    );

    mci_wdt i_wdt (
        .clk,
        .rst_n_i,
        .t1_en_i       (t1_en),
        .t1_restart_i  (t1_restart),
        .t2_restart_i  (t2_restart),
        .t1_period_i   (t1_period),
        .t2_period_i   (t2_period),
        .t1_serviced_i (t1_serviced),
        .t2_serviced_i (t2_serviced),
        .t1_timeout_o  (t1_timeout),
        .t2_timeout_o  (t2_timeout)
    );

    mci_err_agg #(
        .ERR_W (ERR_W)
    ) i_err_agg (
        .clk,
        .rst_n_i,
        .agg_error_fatal_i,
        .agg_error_non_fatal_i,
        .fatal_clr_i        (fatal_clr),
        .nonfatal_clr_i     (nonfatal_clr),
        .fatal_mask_we_i    (fatal_mask_we),
        .nonfatal_mask_we_i (nonfatal_mask_we),
        .err_wdata_i        (err_wdata),
        .t1_timeout_i       (t1_timeout),
        .t2_timeout_i       (t2_timeout),
        .fatal_sts_o        (fatal_sts),
        .nonfatal_sts_o     (nonfatal_sts),
        .fatal_mask_o       (fatal_mask),
        .nonfatal_mask_o    (nonfatal_mask),
        .all_error_fatal_o,
        .all_error_non_fatal_o,
        .mci_intr_o,
        .nmi_intr_o
    );

endmodule

/* src/mci_wdt.sv */
`timescale 1ns/10ps

module mci_wdt (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            t1_en_i,
    input  logic                            t1_restart_i,
    input  logic                            t2_restart_i,
    input  logic [mci_lite_pkg::DATA_W-1:0] t1_period_i,
    input  logic [mci_lite_pkg::DATA_W-1:0] t2_period_i,
    input  logic                            t1_serviced_i,
    input  logic                            t2_serviced_i,
    output logic                            t1_timeout_o,
    output logic                            t2_timeout_o
);
    import mci_lite_pkg::*;

    logic [DATA_W-1:0] t1_cnt_q;
    logic [DATA_W-1:0] t2_cnt_q;
    logic              t1_timeout_q;
    logic              t2_timeout_q;

    ////////////////////
    // Timer 1
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            t1_cnt_q     <= '0;
            t1_timeout_q <= 1'b0;
        end else if (t1_serviced_i) begin
            t1_cnt_q     <= '0;
            t1_timeout_q <= 1'b0;
        end else if (t1_restart_i) begin
            t1_cnt_q <= '0;
        end else if (t1_en_i && !t1_timeout_q) begin
            if (t1_cnt_q == t1_period_i) begin
                t1_cnt_q     <= '0;
                t1_timeout_q <= 1'b1;
            end else begin
                t1_cnt_q <= t1_cnt_q + 1'b1;
            end
        end
    end

    ////////////////////
    // Timer 2
    ////////////////////

    // Only runs while timer 1 sits in timeout
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            t2_cnt_q     <= '0;
            t2_timeout_q <= 1'b0;
        end else if (t2_serviced_i) begin
            t2_cnt_q     <= '0;
            t2_timeout_q <= 1'b0;
        end else if (t2_restart_i) begin
            t2_cnt_q <= '0;
        end else if (t1_timeout_q && !t2_timeout_q) begin
            if (t2_cnt_q == t2_period_i) begin
                t2_cnt_q     <= '0;
                t2_timeout_q <= 1'b1;
            end else begin
                t2_cnt_q <= t2_cnt_q + 1'b1;
            end
        end
    end

    assign t1_timeout_o = t1_timeout_q;
    assign t2_timeout_o = t2_timeout_q;

endmodule
